//--- sources.f
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_extend.sv
hw/lsu_latency_timer.sv
hw/lsu_data_mem.sv
hw/lsu_fsm.sv
hw/lsu_top.sv
bench/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb
	import lsu_pkg::*;
;

	localparam int MEM_WORDS   = 256;
	localparam int MEM_LATENCY = 2;
	localparam int BYTE_W      = $clog2(MEM_WORDS * 4);

	logic     clock;
	logic     rst_n;
	lsu_req_t req;
	logic     req_valid;
	logic     req_ready;
	lsu_wb_t  wb;
	logic     wb_valid;

	lsu_req_t   req_tab[$];
	lsu_wb_t    exp_tab[$];
	logic [7:0] ref_mem [MEM_WORDS * 4]; // byte model of the data memory
	word_t      lcg_state;
	addr_t      base_a;
	addr_t      base_b;
	addr_t      base_c;
	addr_t      oor;
	int         cycles;
	int         cycle_limit;
	int         wb_errors;
	int         ready_errors;
	int         pulse_errors;

	lsu_top #(
		.MEM_WORDS  (MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) UUT (
		.clock    (clock),
		.rst_n    (rst_n),
		.req      (req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.wb       (wb),
		.wb_valid (wb_valid)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: write-back did not arrive within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic word_t rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_entry(input lsu_op_t op, input funct3_t f3, input addr_t addr,
			input word_t data);
		lsu_req_t r;
		lsu_wb_t  e;
		word_t    rnd;
		word_t    raw;
		logic     bad_align;
		logic     in_range;
		int       nbytes;
		rnd          = rand_next();
		r.op         = op;
		r.funct3     = f3;
		r.rd         = rnd[31:28];
		r.reg_wen    = rnd[16];
		r.addr       = addr;
		r.store_data = data;
		case (f3)
			F3_HALF, F3_HALF_U: nbytes = 2;
			F3_WORD:            nbytes = 4;
			default:            nbytes = 1;
		endcase
		bad_align = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
		in_range  = (addr >> 2) < MEM_WORDS;
		e.rd      = r.rd;
		e.reg_wen = r.reg_wen;
		e.fault   = 1'b0;
		e.value   = addr;
		if (op != OP_PASS && (bad_align || !in_range)) begin
			e.fault = 1'b1;
			e.value = '0;
		end else if (op == OP_STORE) begin
			for (int i = 0; i < nbytes; i++)
				ref_mem[BYTE_W'(addr + i)] = data[8*i +: 8];
		end else if (op == OP_LOAD) begin
			raw = '0;
			for (int i = 0; i < nbytes; i++)
				raw[8*i +: 8] = ref_mem[BYTE_W'(addr + i)];
			case (f3)
				F3_BYTE: e.value = {{24{raw[7]}}, raw[7:0]};
				F3_HALF: e.value = {{16{raw[15]}}, raw[15:0]};
				default: e.value = raw; // upper bytes already zero
			endcase
		end
		req_tab.push_back(r);
		exp_tab.push_back(e);
	endtask

	task automatic check_wb(input lsu_wb_t got, input lsu_wb_t exp, input int n);
		if (got.rd !== exp.rd) begin
			wb_errors++;
			$display("CHECK FAILED entry %0d wb.rd got %h expected %h", n, got.rd, exp.rd);
		end
		if (got.reg_wen !== exp.reg_wen) begin
			wb_errors++;
			$display("CHECK FAILED entry %0d wb.reg_wen got %h expected %h", n,
				got.reg_wen, exp.reg_wen);
		end
		if (got.value !== exp.value) begin
			wb_errors++;
			$display("CHECK FAILED entry %0d wb.value got %h expected %h", n,
				got.value, exp.value);
		end
		if (got.fault !== exp.fault) begin
			wb_errors++;
			$display("CHECK FAILED entry %0d wb.fault got %h expected %h", n,
				got.fault, exp.fault);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string where);
		if (got !== exp) begin
			ready_errors++;
			$display("CHECK FAILED req_ready %s got %h expected %h", where, got, exp);
		end
	endtask

	task automatic run_entry(input int n);
		req       = req_tab[n];
		req_valid = 1'b1;
		check_ready(req_ready, 1'b1, "before accept");
		@(posedge clock); // accept edge
		@(negedge clock);
		req_valid = 1'b0;
		req       = '0;
		while (!wb_valid) begin
			check_ready(req_ready, 1'b0, "while in flight");
			@(negedge clock);
		end
		check_wb(wb, exp_tab[n], n);
		check_ready(req_ready, 1'b0, "during write-back");
		@(negedge clock);
		if (wb_valid !== 1'b0) begin
			pulse_errors++;
			$display("entry %0d: wb_valid stayed high for more than one cycle", n);
		end
		check_ready(req_ready, 1'b1, "after write-back");
	endtask

	initial begin
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req          = '0;
		cycles       = 0;
		cycle_limit  = 0;
		wb_errors    = 0;
		ready_errors = 0;
		pulse_errors = 0;
		lcg_state    = 32'd57;

		base_a = ((rand_next() >> 8) % (MEM_WORDS - 2)) << 2; // three words in range
		base_b = base_a + 4;
		base_c = base_a + 8;
		oor    = MEM_WORDS * 4 + base_a; // same low bits as base_a

		add_entry(OP_PASS, F3_WORD, rand_next(), rand_next());
		add_entry(OP_PASS, F3_HALF, rand_next() | 32'h1, rand_next()); // odd, still no fault
		add_entry(OP_STORE, F3_WORD, base_a, rand_next());
		add_entry(OP_STORE, F3_BYTE, base_a, rand_next());
		add_entry(OP_STORE, F3_BYTE, base_a + 1, rand_next());
		add_entry(OP_STORE, F3_HALF, base_a + 2, rand_next());
		add_entry(OP_LOAD, F3_WORD, base_a, '0);
		add_entry(OP_STORE, F3_WORD, base_b, rand_next());
		add_entry(OP_STORE, F3_BYTE, base_b + 2, rand_next());
		add_entry(OP_STORE, F3_BYTE, base_b + 3, rand_next());
		add_entry(OP_STORE, F3_HALF, base_b, rand_next());
		add_entry(OP_LOAD, F3_WORD, base_b, '0);
		// bytes 0 and 1 negative, 2 and 3 positive
		add_entry(OP_STORE, F3_WORD, base_c, (rand_next() & 32'h7f7f_7f7f) | 32'h0000_8080);
		for (int i = 0; i < 4; i++) begin
			add_entry(OP_LOAD, F3_BYTE, base_c + i, '0);
			add_entry(OP_LOAD, F3_BYTE_U, base_c + i, '0);
		end
		for (int i = 0; i < 4; i += 2) begin
			add_entry(OP_LOAD, F3_HALF, base_c + i, '0);
			add_entry(OP_LOAD, F3_HALF_U, base_c + i, '0);
		end
		add_entry(OP_STORE, F3_HALF, base_a + 1, rand_next());
		add_entry(OP_STORE, F3_WORD, base_b + 2, rand_next());
		add_entry(OP_LOAD, F3_HALF_U, base_c + 3, '0);
		add_entry(OP_LOAD, F3_WORD, base_c + 1, '0);
		add_entry(OP_LOAD, F3_WORD, base_a, '0);
		add_entry(OP_LOAD, F3_WORD, base_b, '0);
		add_entry(OP_LOAD, F3_WORD, oor, '0);
		add_entry(OP_STORE, F3_WORD, oor, rand_next());
		add_entry(OP_LOAD, F3_BYTE, oor + 1, '0);
		add_entry(OP_LOAD, F3_WORD, oor, '0);
		add_entry(OP_LOAD, F3_WORD, base_a, '0);
		add_entry(OP_LOAD, F3_WORD, base_c, '0);
		cycle_limit = req_tab.size() * (MEM_LATENCY + 10) + 50;

		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		check_ready(req_ready, 1'b1, "after reset");
		if (wb_valid !== 1'b0 || wb.fault !== 1'b0) begin
			pulse_errors++;
			$display("wb_valid or wb.fault not cleared by reset");
		end

		for (int n = 0; n < req_tab.size(); n++)
			run_entry(n);

		$display("errors: write-back %0d, req_ready %0d, wb_valid %0d",
			wb_errors, ready_errors, pulse_errors);
		if (wb_errors + ready_errors + pulse_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
	import lsu_pkg::*;
#(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  logic     clock,
	input  logic     rst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output lsu_wb_t  wb,
	output logic     wb_valid
);

	axi_m2s_t axi_req;
	axi_s2m_t axi_rsp;

	lsu_fsm u_fsm (
		.clock    (clock),
		.rst_n    (rst_n),
		.req      (req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.axi_out  (axi_req),
		.axi_in   (axi_rsp),
		.wb       (wb),
		.wb_valid (wb_valid)
	);

	lsu_data_mem #(
		.MEM_WORDS  (MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_data_mem (
		.clock  (clock),
		.rst_n  (rst_n),
		.axi_in (axi_req),
		.axi_out(axi_rsp)
	);

endmodule

//--- hw/lsu_fsm.sv
`timescale 1ns/1ps

module lsu_fsm
	import lsu_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output axi_m2s_t axi_out,
	input  axi_s2m_t axi_in,
	output lsu_wb_t  wb,
	output logic     wb_valid
);

	lsu_state_t state;
	lsu_req_t   req_q;
	logic       misaligned_q;
	axi_resp_t  resp_q;
	word_t      load_q;
	logic       aw_done;
	logic       w_done;

	word_t      wdata;
	strb_t      wstrb;
	logic [2:0] size;
	word_t      load_value;
	logic       accept;
	logic       misaligned;
	logic       aw_hs;
	logic       w_hs;
	logic       fault;

	assign req_ready = (state == ST_IDLE) && !wb_valid;
	assign accept    = req_valid && req_ready;
	assign aw_hs     = axi_out.awvalid && axi_in.awready;
	assign w_hs      = axi_out.wvalid && axi_in.wready;
	assign fault     = misaligned_q || (resp_q != RESP_OKAY);

	always_comb begin
		misaligned = 1'b0;
		if (req.op != OP_PASS) begin
			case (req.funct3)
				F3_HALF, F3_HALF_U: misaligned = req.addr[0];
				F3_WORD:            misaligned = |req.addr[1:0];
				default:            misaligned = 1'b0;
			endcase
		end
	end

	lsu_store_align u_store_align (
		.addr      (req_q.addr),
		.funct3    (req_q.funct3),
		.store_data(req_q.store_data),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.size      (size)
	);

	lsu_load_extend u_load_extend (
		.addr  (req_q.addr),
		.funct3(req_q.funct3),
		.rdata (axi_in.rdata),
		.value (load_value)
	);

	always_comb begin
		axi_out.arvalid = (state == ST_READ_ADDR);
		axi_out.araddr  = req_q.addr;
		axi_out.arsize  = size; // same size on both address channels
		axi_out.awvalid = (state == ST_WRITE) && !aw_done;
		axi_out.awaddr  = req_q.addr;
		axi_out.awsize  = size;
		axi_out.wvalid  = (state == ST_WRITE) && !w_done;
		axi_out.wdata   = wdata;
		axi_out.wstrb   = wstrb;
		axi_out.rready  = 1'b1;
		axi_out.bready  = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			wb_valid <= 1'b0;
			wb       <= '0;
		end else begin
			wb_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (req.op == OP_PASS || misaligned)
							state <= ST_WRITEBACK; // no bus access
						else if (req.op == OP_LOAD)
							state <= ST_READ_ADDR;
						else
							state <= ST_WRITE;
					end
				end
				ST_READ_ADDR: begin
					if (axi_in.arready)
						state <= ST_READ_DATA;
				end
				ST_READ_DATA: begin
					if (axi_in.rvalid)
						state <= ST_WRITEBACK;
				end
				ST_WRITE: begin
					if (aw_hs)
						aw_done <= 1'b1;
					if (w_hs)
						w_done <= 1'b1;
					if ((aw_done || aw_hs) && (w_done || w_hs)) begin
						aw_done <= 1'b0;
						w_done  <= 1'b0;
						state   <= ST_WRITE_RESP;
					end
				end
				ST_WRITE_RESP: begin
					if (axi_in.bvalid)
						state <= ST_WRITEBACK;
				end
				ST_WRITEBACK: begin
					wb.rd      <= req_q.rd;
					wb.reg_wen <= req_q.reg_wen;
					wb.fault   <= fault;
					if (fault)
						wb.value <= '0;
					else if (req_q.op == OP_LOAD)
						wb.value <= load_q;
					else
						wb.value <= req_q.addr; // pass and store
					wb_valid <= 1'b1;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q        <= req;
			misaligned_q <= misaligned;
			resp_q       <= RESP_OKAY;
		end
		if (state == ST_READ_DATA && axi_in.rvalid) begin
			load_q <= load_value;
			resp_q <= axi_in.rresp;
		end
		if (state == ST_WRITE_RESP && axi_in.bvalid)
			resp_q <= axi_in.bresp;
	end

endmodule

//--- hw/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem
	import lsu_pkg::*;
#(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  logic     clock,
	input  logic     rst_n,
	input  axi_m2s_t axi_in,
	output axi_s2m_t axi_out
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	word_t     mem [MEM_WORDS];
	addr_t     addr_q;
	word_t     wdata_q;
	strb_t     wstrb_q;
	word_t     rdata_q;
	axi_resp_t resp_q;

	logic rd_active;
	logic wr_active;
	logic aw_got;
	logic w_got;
	logic rvalid;
	logic bvalid;
	logic idle;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic wr_start;
	logic timer_done;
	logic in_range;

	assign idle     = !rd_active && !wr_active && !rvalid && !bvalid;
	assign ar_hs    = axi_in.arvalid && axi_out.arready;
	assign aw_hs    = axi_in.awvalid && axi_out.awready;
	assign w_hs     = axi_in.wvalid && axi_out.wready;
	assign wr_start = (aw_got || aw_hs) && (w_got || w_hs);
	assign in_range = {2'b00, addr_q[31:2]} < MEM_WORDS;

	assign axi_out.arready = idle && !aw_got && !w_got;
	assign axi_out.awready = idle && !aw_got;
	assign axi_out.wready  = idle && !w_got;
	assign axi_out.rvalid  = rvalid;
	assign axi_out.rdata   = rdata_q;
	assign axi_out.rresp   = resp_q;
	assign axi_out.bvalid  = bvalid;
	assign axi_out.bresp   = resp_q;

	lsu_latency_timer #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_timer (
		.clock(clock),
		.rst_n(rst_n),
		.start(ar_hs || wr_start),
		.done (timer_done)
	);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_active <= 1'b0;
			wr_active <= 1'b0;
			aw_got    <= 1'b0;
			w_got     <= 1'b0;
			rvalid    <= 1'b0;
			bvalid    <= 1'b0;
		end else begin
			if (ar_hs)
				rd_active <= 1'b1;
			if (aw_hs)
				aw_got <= 1'b1;
			if (w_hs)
				w_got <= 1'b1;
			if (wr_start) begin
				wr_active <= 1'b1;
				aw_got    <= 1'b0;
				w_got     <= 1'b0;
			end
			if (timer_done) begin
				rd_active <= 1'b0;
				wr_active <= 1'b0;
				rvalid    <= rd_active;
				bvalid    <= wr_active;
			end
			if (rvalid && axi_in.rready)
				rvalid <= 1'b0;
			if (bvalid && axi_in.bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs)
			addr_q <= axi_in.araddr;
		if (aw_hs)
			addr_q <= axi_in.awaddr;
		if (w_hs) begin
			wdata_q <= axi_in.wdata;
			wstrb_q <= axi_in.wstrb;
		end
		if (timer_done) begin
			resp_q  <= in_range ? RESP_OKAY : RESP_SLVERR;
			rdata_q <= in_range ? mem[addr_q[IDX_W+1:2]] : '0; // 0 on slverr
			if (wr_active && in_range) begin
				for (int b = 0; b < 4; b++) begin
					if (wstrb_q[b])
						mem[addr_q[IDX_W+1:2]][8*b +: 8] <= wdata_q[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- hw/lsu_latency_timer.sv
`timescale 1ns/1ps

module lsu_latency_timer #(
	parameter int MEM_LATENCY = 2
) (
	input  logic clock,
	input  logic rst_n,
	input  logic start,
	output logic done
);

	localparam int CW = $clog2(MEM_LATENCY + 2);

	logic [CW-1:0] count;
	logic          busy;

	assign done = busy && (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= CW'(MEM_LATENCY);
		end else if (busy) begin
			if (count == '0)
				busy <= 1'b0; // expired, wait for next start
			else
				count <= count - 1'b1;
		end
	end

endmodule

//--- hw/lsu_load_extend.sv
`timescale 1ns/1ps

module lsu_load_extend
	import lsu_pkg::*;
(
	input  addr_t   addr,
	input  funct3_t funct3,
	input  word_t   rdata,
	output word_t   value
);

	word_t shifted;

	assign shifted = rdata >> {addr[1:0], 3'b000}; // addressed byte to bit 0

	always_comb begin
		case (funct3)
			F3_BYTE:   value = {{24{shifted[7]}}, shifted[7:0]};
			F3_HALF:   value = {{16{shifted[15]}}, shifted[15:0]};
			F3_WORD:   value = shifted;
			F3_BYTE_U: value = {24'h000000, shifted[7:0]};
			F3_HALF_U: value = {16'h0000, shifted[15:0]};
			default:   value = '0;
		endcase
	end

endmodule

//--- hw/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align
	import lsu_pkg::*;
(
	input  addr_t      addr,
	input  funct3_t    funct3,
	input  word_t      store_data,
	output word_t      wdata,
	output strb_t      wstrb,
	output logic [2:0] size
);

	strb_t mask;

	always_comb begin
		case (funct3[1:0])
			2'b00:   mask = 4'b0001; // byte
			2'b01:   mask = 4'b0011; // half
			default: mask = 4'b1111;
		endcase
	end

	assign wstrb = mask << addr[1:0];
	assign wdata = store_data << {addr[1:0], 3'b000}; // lane of the low byte
	assign size  = {1'b0, funct3[1:0]};

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	typedef enum logic [2:0] {
		F3_BYTE   = 3'b000,
		F3_HALF   = 3'b001,
		F3_WORD   = 3'b010,
		F3_BYTE_U = 3'b100,
		F3_HALF_U = 3'b101
	} funct3_t;

	typedef enum logic [1:0] {
		OP_PASS  = 2'b00,
		OP_LOAD  = 2'b01,
		OP_STORE = 2'b10
	} lsu_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ_ADDR,
		ST_READ_DATA,
		ST_WRITE,
		ST_WRITE_RESP,
		ST_WRITEBACK
	} lsu_state_t;

	typedef struct packed {
		lsu_op_t  op;
		funct3_t  funct3;
		reg_idx_t rd;
		logic     reg_wen;
		addr_t    addr; // execute result
		word_t    store_data;
	} lsu_req_t;

	typedef struct packed {
		reg_idx_t rd;
		logic     reg_wen;
		word_t    value;
		logic     fault;
	} lsu_wb_t;

	typedef struct packed {
		logic       arvalid;
		addr_t      araddr;
		logic [2:0] arsize;
		logic       awvalid;
		addr_t      awaddr;
		logic [2:0] awsize;
		logic       wvalid;
		word_t      wdata;
		strb_t      wstrb;
		logic       rready;
		logic       bready;
	} axi_m2s_t;

	typedef struct packed {
		logic      arready;
		logic      awready;
		logic      wready;
		logic      rvalid;
		word_t     rdata;
		axi_resp_t rresp;
		logic      bvalid;
		axi_resp_t bresp;
	} axi_s2m_t;

endpackage
